//--- include/board_cfg.svh
// -----------------------------------------------------------
// Board build constants; the status bit positions must match the OSD menu
// -----------------------------------------------------------
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// Game colour width per channel
`define BOARD_COLORW      4

// Reset sequencing, in clk_sys cycles
`define BOARD_RST_HOLD    16
`define BOARD_GAME_HOLD   8

// Vertical blanks between LED toggles while downloading
`define BOARD_LED_BLINK   8

// OSD status word bit positions
`define BOARD_ST_ROTATE   2
`define BOARD_ST_FLIP     3
`define BOARD_ST_FM_OFF   4
`define BOARD_ST_PSG_OFF  5
`define BOARD_ST_PAUSE    6
`define BOARD_ST_TEST     7
`define BOARD_ST_SCAN     8
`define BOARD_ST_BW       11
`define BOARD_ST_AUTOFIRE 18

`endif

//--- design/board_pkg.sv
// -----------------------------------------------------------
// Board control types; status_t layout follows the BOARD_ST_* positions
// -----------------------------------------------------------
`default_nettype none

`include "board_cfg.svh"

package board_pkg;

    // OSD status word, bit 63 first
    typedef struct packed {
        logic [62-`BOARD_ST_AUTOFIRE:0]            rsv_hi;
        logic                                      autofire;
        logic [`BOARD_ST_AUTOFIRE-`BOARD_ST_BW-2:0] rsv_mid;
        logic                                      bw_en;
        logic [2:0]                                scanlines;
        logic                                      test;
        logic                                      pause;
        logic                                      psg_off;
        logic                                      fm_off;
        logic                                      flip;
        logic                                      rotate;
        logic [`BOARD_ST_ROTATE-1:0]               rsv_lo;
    } status_t;

    typedef struct packed {
        logic       rotate;
        logic       flip;
        logic       enable_fm;
        logic       enable_psg;
        logic       pause;
        logic       test;
        logic [2:0] scanlines;
        logic       bw_en;
        logic       autofire;
    } dip_t;

    // Button 1 is buttons[0]
    typedef struct packed {
        logic [5:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } joy_t;

    typedef struct packed {
        logic rst;
        logic rst_n;
        logic game_rst;
        logic game_rst_n;
    } board_rst_t;

endpackage

`default_nettype wire

//--- design/video_pkg.sv
// -----------------------------------------------------------
// Video stage types; colour width comes from BOARD_COLORW
// -----------------------------------------------------------
`default_nettype none

`include "board_cfg.svh"

package video_pkg;

    // Game colour as produced by the core
    typedef struct packed {
        logic [`BOARD_COLORW-1:0] r;
        logic [`BOARD_COLORW-1:0] g;
        logic [`BOARD_COLORW-1:0] b;
    } rgb_t;

    // One extra bit after the bandwidth filter
    typedef struct packed {
        logic [`BOARD_COLORW:0] r;
        logic [`BOARD_COLORW:0] g;
        logic [`BOARD_COLORW:0] b;
    } rgb_wide_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8_t;

    // Blanking signals are active low
    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;
        logic lvbl;
    } sync_t;

endpackage

`default_nettype wire

//--- design/board_reset.sv
// -----------------------------------------------------------
// rst is async on arst_n, held BOARD_RST_HOLD cycles after lock
// -----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module board_reset (
    input  wire logic                  clk_sys,
    input  wire logic                  arst_n,
    input  wire logic                  pll_locked,
    input  wire logic                  rst_req,
    input  wire logic                  downloading,
    output board_pkg::board_rst_t      board_rst
);

    localparam int RW = $clog2(`BOARD_RST_HOLD + 1);
    localparam int GW = $clog2(`BOARD_GAME_HOLD + 1);

    logic [RW-1:0] rst_cnt;
    logic [GW-1:0] game_cnt;
    logic          rst_cause;
    logic          rst;
    logic          game_rst;

    assign rst_cause = ~pll_locked | rst_req;

    // System reset hold counter
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            rst_cnt <= RW'(`BOARD_RST_HOLD);
        end else if (rst_cause) begin
            rst_cnt <= RW'(`BOARD_RST_HOLD);
        end else if (rst_cnt != '0) begin
            rst_cnt <= rst_cnt - 1'b1;
        end
    end

    // Game reset extends past rst and any download
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            game_cnt <= GW'(`BOARD_GAME_HOLD);
        end else if (rst || downloading) begin
            game_cnt <= GW'(`BOARD_GAME_HOLD);
        end else if (game_cnt != '0) begin
            game_cnt <= game_cnt - 1'b1;
        end
    end

    assign rst      = rst_cnt != '0;
    // OR with rst so the game reset never lags the first cycle
    assign game_rst = rst | (game_cnt != '0);

    assign board_rst.rst        = rst;
    assign board_rst.rst_n      = ~rst;
    assign board_rst.game_rst   = game_rst;
    assign board_rst.game_rst_n = ~game_rst;

endmodule

`default_nettype wire

//--- design/board_dip.sv
// -----------------------------------------------------------
// OSD settings are one cycle behind status; FM and PSG on by default
// -----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module board_dip (
    input  wire logic              clk_sys,
    input  wire logic              arst_n,
    input  wire logic              rst,
    input  board_pkg::status_t     status,
    input  wire logic              osd_shown,
    output board_pkg::dip_t        dip
);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            dip            <= '0;
            dip.enable_fm  <= 1'b1;
            dip.enable_psg <= 1'b1;
        end else if (rst) begin
            dip            <= '0;
            dip.enable_fm  <= 1'b1;
            dip.enable_psg <= 1'b1;
        end else begin
            dip.rotate     <= status.rotate;
            dip.flip       <= status.flip;
            // Menu bits are "off" switches
            dip.enable_fm  <= ~status.fm_off;
            dip.enable_psg <= ~status.psg_off;
            // Game stops while the OSD is open
            dip.pause      <= status.pause | osd_shown;
            dip.test       <= status.test;
            dip.scanlines  <= status.scanlines;
            dip.bw_en      <= status.bw_en;
            dip.autofire   <= status.autofire;
        end
    end

endmodule

`default_nettype wire

//--- design/board_inputs.sv
// -----------------------------------------------------------
// Board inputs are active high; game side is active low, one cycle later
// -----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module board_inputs (
    input  wire logic           clk_sys,
    input  wire logic           arst_n,
    input  wire logic           rst,
    input  wire logic           vs,
    input  wire logic           flip,
    input  wire logic           autofire,
    input  board_pkg::joy_t     board_joystick1,
    input  board_pkg::joy_t     board_joystick2,
    input  wire logic [1:0]     board_start,
    input  wire logic [1:0]     board_coin,
    output board_pkg::joy_t     game_joystick1,
    output board_pkg::joy_t     game_joystick2,
    output logic      [1:0]     game_start,
    output logic      [1:0]     game_coin
);

    logic       vs_l;
    logic       vs_rise;
    logic [1:0] phase;

    // Flip, autofire and active-low conversion for one player
    function automatic board_pkg::joy_t cond_joy(
        input board_pkg::joy_t j,
        input logic            flip_en,
        input logic            af_en,
        input logic            ph
    );
        board_pkg::joy_t c;
        c = j;
        if (flip_en) begin
            c.up    = j.down;
            c.down  = j.up;
            c.left  = j.right;
            c.right = j.left;
        end
        if (af_en && j.buttons[0]) begin
            c.buttons[0] = ph;
        end
        return board_pkg::joy_t'(~c);
    endfunction

    assign vs_rise = vs & ~vs_l;

    // Autofire phase per player, restarts when button 1 is let go
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            vs_l  <= 1'b0;
            phase <= '0;
        end else if (rst) begin
            vs_l  <= 1'b0;
            phase <= '0;
        end else begin
            vs_l <= vs;
            if (!board_joystick1.buttons[0]) begin
                phase[0] <= 1'b0;
            end else if (vs_rise) begin
                phase[0] <= ~phase[0];
            end
            if (!board_joystick2.buttons[0]) begin
                phase[1] <= 1'b0;
            end else if (vs_rise) begin
                phase[1] <= ~phase[1];
            end
        end
    end

    // Released level is all ones
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            game_joystick1 <= '1;
            game_joystick2 <= '1;
            game_start     <= '1;
            game_coin      <= '1;
        end else if (rst) begin
            game_joystick1 <= '1;
            game_joystick2 <= '1;
            game_start     <= '1;
            game_coin      <= '1;
        end else begin
            game_joystick1 <= cond_joy(board_joystick1, flip, autofire, phase[0]);
            game_joystick2 <= cond_joy(board_joystick2, flip, autofire, phase[1]);
            game_start     <= ~board_start;
            game_coin      <= ~board_coin;
        end
    end

endmodule

`default_nettype wire

//--- design/board_led.sv
// -----------------------------------------------------------
// Blink rate depends on the game frame rate while downloading
// -----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module board_led (
    input  wire logic clk_sys,
    input  wire logic arst_n,
    input  wire logic rst,
    input  wire logic lvbl,
    input  wire logic downloading,
    input  wire logic osd_shown,
    input  wire logic game_led,
    output logic      led
);

    localparam int CW = $clog2(`BOARD_LED_BLINK);

    logic          lvbl_l;
    logic [CW-1:0] vb_cnt;
    logic          blink;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            lvbl_l <= 1'b0;
            vb_cnt <= '0;
            blink  <= 1'b0;
            led    <= 1'b0;
        end else if (rst) begin
            lvbl_l <= 1'b0;
            vb_cnt <= '0;
            blink  <= 1'b0;
            led    <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (!downloading) begin
                // Next download starts from a clean count
                vb_cnt <= '0;
                blink  <= 1'b0;
            end else if (lvbl_l && !lvbl) begin
                if (vb_cnt == CW'(`BOARD_LED_BLINK - 1)) begin
                    vb_cnt <= '0;
                    blink  <= ~blink;
                end else begin
                    vb_cnt <= vb_cnt + 1'b1;
                end
            end
            led <= downloading ? blink : (game_led ^ osd_shown);
        end
    end

endmodule

`default_nettype wire

//--- design/video_bw_out.sv
// -----------------------------------------------------------
// Outputs update only on pxl_cen; the filter averages adjacent pixels
// -----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module video_bw_out (
    input  wire logic          clk_sys,
    input  wire logic          arst_n,
    input  wire logic          rst,
    input  wire logic          pxl_cen,
    input  wire logic          bw_en,
    input  video_pkg::rgb_t    game_rgb,
    input  video_pkg::sync_t   game_sync,
    output video_pkg::rgb8_t   video_rgb,
    output video_pkg::sync_t   video_sync,
    output logic               video_de
);

    localparam int CW = `BOARD_COLORW;
    localparam int WW = `BOARD_COLORW + 1;

    video_pkg::rgb_t      prev;
    video_pkg::rgb_wide_t wide;

    // Sum of two pixels, or the pixel doubled when the filter is off
    function automatic logic [WW-1:0] filt(
        input logic [CW-1:0] cur,
        input logic [CW-1:0] last,
        input logic          en
    );
        return en ? (WW'(cur) + WW'(last)) : {cur, 1'b0};
    endfunction

    // Replicate the top bits into the new LSBs
    function automatic logic [7:0] expand8(input logic [WW-1:0] c);
        return {c, c[WW-1 -: 8-WW]};
    endfunction

    assign wide.r = filt(game_rgb.r, prev.r, bw_en);
    assign wide.g = filt(game_rgb.g, prev.g, bw_en);
    assign wide.b = filt(game_rgb.b, prev.b, bw_en);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            prev       <= '0;
            video_rgb  <= '0;
            video_sync <= '0;
            video_de   <= 1'b0;
        end else if (rst) begin
            prev       <= '0;
            video_rgb  <= '0;
            video_sync <= '0;
            video_de   <= 1'b0;
        end else if (pxl_cen) begin
            prev        <= game_rgb;
            video_rgb.r <= expand8(wide.r);
            video_rgb.g <= expand8(wide.g);
            video_rgb.b <= expand8(wide.b);
            video_sync  <= game_sync;
            video_de    <= game_sync.lhbl & game_sync.lvbl;
        end
    end

endmodule

`default_nettype wire

//--- design/board_top.sv
// -----------------------------------------------------------
// Single clock domain; game_led bit 1 is not shown on the board LED
// -----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module board_top (
    input  wire logic               clk_sys,
    input  wire logic               arst_n,
    input  wire logic               pll_locked,
    input  wire logic               rst_req,
    input  wire logic               downloading,
    input  board_pkg::status_t      status,
    input  board_pkg::joy_t         board_joystick1,
    input  board_pkg::joy_t         board_joystick2,
    input  wire logic [1:0]         board_start,
    input  wire logic [1:0]         board_coin,
    input  wire logic               osd_shown,
    input  wire logic [1:0]         game_led,
    input  video_pkg::rgb_t         game_rgb,
    input  video_pkg::sync_t        game_sync,
    input  wire logic               pxl_cen,
    output board_pkg::board_rst_t   board_rst,
    output board_pkg::dip_t         dip,
    output board_pkg::joy_t         game_joystick1,
    output board_pkg::joy_t         game_joystick2,
    output logic      [1:0]         game_start,
    output logic      [1:0]         game_coin,
    output logic                    led,
    output video_pkg::rgb8_t        video_rgb,
    output video_pkg::sync_t        video_sync,
    output logic                    video_de
);

    board_reset u_reset (
        .clk_sys     ( clk_sys        ),
        .arst_n      ( arst_n         ),
        .pll_locked  ( pll_locked     ),
        .rst_req     ( rst_req        ),
        .downloading ( downloading    ),
        .board_rst   ( board_rst      )
    );

    board_dip u_dip (
        .clk_sys     ( clk_sys        ),
        .arst_n      ( arst_n         ),
        .rst         ( board_rst.rst  ),
        .status      ( status         ),
        .osd_shown   ( osd_shown      ),
        .dip         ( dip            )
    );

    board_inputs u_inputs (
        .clk_sys         ( clk_sys         ),
        .arst_n          ( arst_n          ),
        .rst             ( board_rst.rst   ),
        .vs              ( game_sync.vs    ),
        .flip            ( dip.flip        ),
        .autofire        ( dip.autofire    ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .board_start     ( board_start     ),
        .board_coin      ( board_coin      ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_start      ( game_start      ),
        .game_coin       ( game_coin       )
    );

    board_led u_led (
        .clk_sys     ( clk_sys        ),
        .arst_n      ( arst_n         ),
        .rst         ( board_rst.rst  ),
        .lvbl        ( game_sync.lvbl ),
        .downloading ( downloading    ),
        .osd_shown   ( osd_shown      ),
        .game_led    ( game_led[0]    ),
        .led         ( led            )
    );

    video_bw_out u_video (
        .clk_sys     ( clk_sys        ),
        .arst_n      ( arst_n         ),
        .rst         ( board_rst.rst  ),
        .pxl_cen     ( pxl_cen        ),
        .bw_en       ( dip.bw_en      ),
        .game_rgb    ( game_rgb       ),
        .game_sync   ( game_sync      ),
        .video_rgb   ( video_rgb      ),
        .video_sync  ( video_sync     ),
        .video_de    ( video_de       )
    );

endmodule

`default_nettype wire

//--- bench/board_tb.sv
// -----------------------------------------------------------
// Needs BOARD_COLORW of 4; compares every output on each falling edge
// -----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "board_cfg.svh"

module board_tb;

    localparam int TEST_CYCLES = 1100;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 400) * 10;

    logic                  clk_sys;
    logic                  arst_n;
    logic                  pll_locked;
    logic                  rst_req;
    logic                  downloading;
    logic                  osd_shown;
    logic                  pxl_cen;
    logic [1:0]            board_start;
    logic [1:0]            board_coin;
    logic [1:0]            game_led;
    board_pkg::status_t    status;
    board_pkg::joy_t       board_joystick1;
    board_pkg::joy_t       board_joystick2;
    video_pkg::rgb_t       game_rgb;
    video_pkg::sync_t      game_sync;

    board_pkg::board_rst_t board_rst;
    board_pkg::dip_t       dip;
    board_pkg::joy_t       game_joystick1;
    board_pkg::joy_t       game_joystick2;
    logic [1:0]            game_start;
    logic [1:0]            game_coin;
    logic                  led;
    video_pkg::rgb8_t      video_rgb;
    video_pkg::sync_t      video_sync;
    logic                  video_de;

    // Expected outputs and the bench's own state model
    board_pkg::board_rst_t exp_rst;
    board_pkg::dip_t       exp_dip;
    board_pkg::joy_t       exp_joy1;
    board_pkg::joy_t       exp_joy2;
    logic [1:0]            exp_start;
    logic [1:0]            exp_coin;
    logic                  exp_led;
    video_pkg::rgb8_t      exp_rgb;
    video_pkg::sync_t      exp_sync;
    logic                  exp_de;
    int                    rst_free;
    int                    game_free;
    int                    vb_falls;
    logic [1:0]            ph;
    logic                  vs_seen;
    logic                  lvbl_seen;
    logic                  blink;
    video_pkg::rgb_t       last_pix;
    logic                  chk_en = 1'b0;
    logic [31:0]           lcg_state = 32'h9c71_78d9;

    board_top dut0 (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    // Linear congruential generator stepped once per call
    function automatic logic [31:0] rnd();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic board_pkg::dip_t dip_ref(input logic [63:0] st, input logic osd);
        board_pkg::dip_t d;
        d.rotate     = st[`BOARD_ST_ROTATE];
        d.flip       = st[`BOARD_ST_FLIP];
        d.enable_fm  = ~st[`BOARD_ST_FM_OFF];
        d.enable_psg = ~st[`BOARD_ST_PSG_OFF];
        d.pause      = st[`BOARD_ST_PAUSE] | osd;
        d.test       = st[`BOARD_ST_TEST];
        d.scanlines  = st[`BOARD_ST_SCAN +: 3];
        d.bw_en      = st[`BOARD_ST_BW];
        d.autofire   = st[`BOARD_ST_AUTOFIRE];
        return d;
    endfunction

    // Bit 0 right, 1 left, 2 down, 3 up, 4 button 1
    function automatic board_pkg::joy_t joy_ref(input logic [9:0] j, input logic flip,
                                                input logic af, input logic phase);
        logic [9:0] v;
        v = j;
        if (flip) begin
            v[3:0] = {j[2], j[3], j[0], j[1]};
        end
        if (af && j[4]) begin
            v[4] = phase;
        end
        return ~v;
    endfunction

    function automatic logic [7:0] pix_ref(input logic [3:0] cur, input logic [3:0] last,
                                           input logic bw);
        logic [4:0] w;
        w = bw ? ({1'b0, cur} + {1'b0, last}) : {cur, 1'b0};
        return {w, w[4:2]};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Every block reacts to the settings and reset from before the edge
    always @(posedge clk_sys) begin
        if (!arst_n || exp_rst.rst) begin
            exp_dip            = '0;
            exp_dip.enable_fm  = 1'b1;
            exp_dip.enable_psg = 1'b1;
            exp_joy1  = '1;
            exp_joy2  = '1;
            exp_start = '1;
            exp_coin  = '1;
            ph        = '0;
            vs_seen   = 1'b0;
            exp_led   = 1'b0;
            lvbl_seen = 1'b0;
            blink     = 1'b0;
            vb_falls  = 0;
            exp_rgb   = '0;
            exp_sync  = '0;
            exp_de    = 1'b0;
            last_pix  = '0;
        end else begin
            exp_joy1  = joy_ref(board_joystick1, exp_dip.flip, exp_dip.autofire, ph[0]);
            exp_joy2  = joy_ref(board_joystick2, exp_dip.flip, exp_dip.autofire, ph[1]);
            exp_start = ~board_start;
            exp_coin  = ~board_coin;
            ph[0] = board_joystick1.buttons[0] ? ph[0] ^ (game_sync.vs & ~vs_seen) : 1'b0;
            ph[1] = board_joystick2.buttons[0] ? ph[1] ^ (game_sync.vs & ~vs_seen) : 1'b0;
            vs_seen = game_sync.vs;
            exp_led = downloading ? blink : (game_led[0] ^ osd_shown);
            if (!downloading) begin
                vb_falls = 0;
                blink    = 1'b0;
            end else if (lvbl_seen && !game_sync.lvbl) begin
                vb_falls++;
                if (vb_falls == `BOARD_LED_BLINK) begin
                    vb_falls = 0;
                    blink    = ~blink;
                end
            end
            lvbl_seen = game_sync.lvbl;
            if (pxl_cen) begin
                exp_rgb.r = pix_ref(game_rgb.r, last_pix.r, exp_dip.bw_en);
                exp_rgb.g = pix_ref(game_rgb.g, last_pix.g, exp_dip.bw_en);
                exp_rgb.b = pix_ref(game_rgb.b, last_pix.b, exp_dip.bw_en);
                exp_sync  = game_sync;
                exp_de    = game_sync.lhbl & game_sync.lvbl;
                last_pix  = game_rgb;
            end
            exp_dip = dip_ref(status, osd_shown);
        end
        // Consecutive edges free of every reset cause
        if (!arst_n || !pll_locked || rst_req) begin
            rst_free = 0;
        end else if (rst_free < `BOARD_RST_HOLD) begin
            rst_free++;
        end
        if (!arst_n || exp_rst.rst || downloading) begin
            game_free = 0;
        end else if (game_free < `BOARD_GAME_HOLD) begin
            game_free++;
        end
        exp_rst.rst        = rst_free < `BOARD_RST_HOLD;
        exp_rst.rst_n      = ~exp_rst.rst;
        exp_rst.game_rst   = exp_rst.rst | (game_free < `BOARD_GAME_HOLD);
        exp_rst.game_rst_n = ~exp_rst.game_rst;
    end

    always @(negedge clk_sys) begin
        if (chk_en) begin
            check_val("board_rst", 32'(board_rst), 32'(exp_rst));
            check_val("dip", 32'(dip), 32'(exp_dip));
            check_val("game_joystick1", 32'(game_joystick1), 32'(exp_joy1));
            check_val("game_joystick2", 32'(game_joystick2), 32'(exp_joy2));
            check_val("game_start", 32'(game_start), 32'(exp_start));
            check_val("game_coin", 32'(game_coin), 32'(exp_coin));
            check_val("led", 32'(led), 32'(exp_led));
            check_val("video_rgb", 32'(video_rgb), 32'(exp_rgb));
            check_val("video_sync", 32'(video_sync), 32'(exp_sync));
            check_val("video_de", 32'(video_de), 32'(exp_de));
        end
    end

    // Counts rising edges until the chosen reset reads low
    // Gives up at 100 edges
    task automatic edges_until_low(input logic game, output int n);
        @(negedge clk_sys);
        n = 1;
        while ((game ? board_rst.game_rst : board_rst.rst) && n < 100) begin
            @(negedge clk_sys);
            n++;
        end
    endtask

    task automatic vs_pulse();
        game_sync.vs = 1'b1;
        repeat (3) @(negedge clk_sys);
        game_sync.vs = 1'b0;
        repeat (3) @(negedge clk_sys);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $fatal(1, "Timeout");
    end

    initial begin
        logic [31:0] r;
        int          i;
        int          f;
        int          n;
        arst_n          = 1'b0;
        pll_locked      = 1'b1;
        rst_req         = 1'b0;
        downloading     = 1'b0;
        osd_shown       = 1'b0;
        pxl_cen         = 1'b0;
        board_start     = '0;
        board_coin      = '0;
        game_led        = '0;
        status          = '0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        game_rgb        = '0;
        game_sync       = '0;
        repeat (10) @(negedge clk_sys);
        arst_n = 1'b1;
        chk_en = 1'b1;

        // Reset sequencing
        edges_until_low(1'b0, n);
        check_val("rst release edges", 32'(n), 32'(`BOARD_RST_HOLD));
        edges_until_low(1'b1, n);
        check_val("game_rst release edges", 32'(n), 32'(`BOARD_GAME_HOLD));
        pll_locked = 1'b0;
        repeat (5) @(negedge clk_sys);
        pll_locked = 1'b1;
        edges_until_low(1'b0, n);
        check_val("rst release edges", 32'(n), 32'(`BOARD_RST_HOLD));
        rst_req = 1'b1;
        repeat (3) @(negedge clk_sys);
        rst_req = 1'b0;
        edges_until_low(1'b0, n);
        check_val("rst release edges", 32'(n), 32'(`BOARD_RST_HOLD));
        downloading = 1'b1;
        repeat (20) @(negedge clk_sys);
        downloading = 1'b0;
        edges_until_low(1'b1, n);
        check_val("game_rst release edges", 32'(n), 32'(`BOARD_GAME_HOLD));

        // Status decoding
        repeat (200) begin
            status    = {rnd(), rnd()};
            r         = rnd();
            osd_shown = r[31];
            @(negedge clk_sys);
        end

        // Player inputs with flip off, then on
        for (f = 0; f < 2; f++) begin
            status      = '0;
            status.flip = f[0];
            repeat (100) begin
                r               = rnd();
                board_joystick1 = r[31:22];
                board_joystick2 = r[21:12];
                board_start     = r[11:10];
                board_coin      = r[9:8];
                game_sync.vs    = r[7];
                status.autofire = r[6];
                @(negedge clk_sys);
            end
        end

        // Autofire, then a release, then autofire off
        status                     = '0;
        status.autofire            = 1'b1;
        board_joystick1            = '0;
        board_joystick2            = '0;
        board_joystick1.buttons[0] = 1'b1;
        board_joystick2.buttons[0] = 1'b1;
        game_sync                  = '0;
        repeat (6) vs_pulse();
        board_joystick2 = '0;
        repeat (2) vs_pulse();
        board_joystick2.buttons[0] = 1'b1;
        status.autofire            = 1'b0;
        repeat (4) vs_pulse();

        // LED outside and during a download
        repeat (50) begin
            r         = rnd();
            game_led  = r[1:0];
            osd_shown = r[2];
            @(negedge clk_sys);
        end
        downloading = 1'b1;
        repeat (40) begin
            game_sync.lvbl = 1'b1;
            repeat (2) @(negedge clk_sys);
            game_sync.lvbl = 1'b0;
            repeat (2) @(negedge clk_sys);
        end
        downloading = 1'b0;

        // Video stage with random strobe gaps
        for (i = 0; i < 300; i++) begin
            r = rnd();
            if (i % 50 == 0) begin
                status.bw_en = ~status.bw_en;
            end
            pxl_cen   = r[31:30] == 2'b00;
            game_rgb  = r[11:0];
            game_sync = r[15:12];
            @(negedge clk_sys);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
design/board_pkg.sv
design/video_pkg.sv
design/board_reset.sv
design/board_dip.sv
design/board_inputs.sv
design/board_led.sv
design/video_bw_out.sv
design/board_top.sv
bench/board_tb.sv

//--- run.sh
#!/bin/sh
# Builds the board testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -j 0 \
    -f project.f --top-module board_tb -o board_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/board_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^=== PASS ===$'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
